// ==== epd_caster.f ====
epd_timing_pkg.sv
epd_pixel_pkg.sv
epd_scan_timing.sv
wvfm_lut.sv
pixel_update.sv
epd_caster.sv
epd_caster_asserts.sv
epd_caster_tb.sv

// ==== epd_caster.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// EPD controller core
// Scan timing, three-stage pixel pipeline with waveform lookup,
// framebuffer write-back and underrun kill
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module epd_caster
    import epd_timing_pkg::*;
    import epd_pixel_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       vin_vsync,
    input  vin_word_t  vin_pixel,
    input  logic       vin_valid,
    output logic       vin_ready,
    input  fb_word_t   bi_pixel,
    input  logic       bi_valid,
    output logic       bi_ready,
    output fb_word_t   bo_pixel,
    output logic       bo_valid,
    input  scan_cfg_t  cfg,
    input  logic       global_en,
    input  logic       sys_ready,
    input  logic       lut_we,
    input  lut_waddr_t lut_waddr,
    input  logic [7:0] lut_wdata,
    output logic       frame_start,
    output logic       epd_gdoe,
    output logic       epd_gdclk,
    output logic       epd_gdsp,
    output logic       epd_sdclk,
    output logic       epd_sdle,
    output logic       epd_sdoe,
    output logic       epd_sdce0,
    output logic [7:0] epd_sd
);

    logic fetch, frame_begin, killable;
    logic kill, kill_hit;
    logic s2_valid, s3_valid;
    logic s2_dead, s3_dead;

    gray_t      s2_gray    [PIX_PER_CLK];
    pix_state_t s2_state   [PIX_PER_CLK];
    pix_state_t s3_state   [PIX_PER_CLK];
    pix_state_t next_state [PIX_PER_CLK];
    wvfm_addr_t lut_raddr  [PIX_PER_CLK];
    drive_t     drive      [PIX_PER_CLK];
    logic [2*PIX_PER_CLK-1:0] lut_rdata;

    epd_scan_timing u_scan (
        .clk         (clk),
        .rst         (rst),
        .cfg         (cfg),
        .global_en   (global_en),
        .sys_ready   (sys_ready),
        .vin_vsync   (vin_vsync),
        .fetch       (fetch),
        .frame_begin (frame_begin),
        .killable    (killable),
        .epd_gdoe    (epd_gdoe),
        .epd_gdclk   (epd_gdclk),
        .epd_gdsp    (epd_gdsp),
        .epd_sdclk   (epd_sdclk),
        .epd_sdle    (epd_sdle),
        .epd_sdoe    (epd_sdoe),
        .epd_sdce0   (epd_sdce0)
    );

    // Both FIFOs are popped together, without looking at valid
    assign vin_ready   = fetch;
    assign bi_ready    = fetch;
    assign frame_start = frame_begin;

    // Both streams dry while fetching
    assign kill_hit = killable && fetch && !vin_valid && !bi_valid;

    // Stage 2 capture, missing words read as zero
    always_ff @(posedge clk) begin
        for (int i = 0; i < PIX_PER_CLK; i++) begin
            s2_gray[i]  <= vin_valid ? vin_pixel[8*i+4 +: 4] : '0;
            s2_state[i] <= bi_valid ? bi_pixel[16*i +: 16] : '0;
            s3_state[i] <= s2_state[i];
        end
    end

    wvfm_lut u_lut (
        .clk   (clk),
        .we    (lut_we),
        .waddr (lut_waddr),
        .wdata (lut_wdata),
        .raddr (lut_raddr),
        .rdata (lut_rdata)
    );

    for (genvar i = 0; i < PIX_PER_CLK; i++) begin : g_pix
        pixel_update u_pix (
            .clk        (clk),
            .lut_frames (cfg.lut_frames),
            .vin_gray   (s2_gray[i]),
            .state_in   (s2_state[i]),
            .drive_rd   (lut_rdata[2*i +: 2]),
            .wvfm_addr  (lut_raddr[i]),
            .state_out  (next_state[i]),
            .drive      (drive[i])
        );
    end

    // Kill tag follows each word down the pipe
    always_ff @(posedge clk) begin
        if (rst) begin
            kill     <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
            s2_dead  <= 1'b0;
            s3_dead  <= 1'b0;
            bo_valid <= 1'b0;
            epd_sd   <= '0;
        end else begin
            if (frame_begin) begin
                kill <= 1'b0;
            end else if (kill_hit) begin
                kill <= 1'b1;
            end
            s2_valid <= fetch;
            s3_valid <= s2_valid;
            bo_valid <= s3_valid;
            s2_dead  <= kill || kill_hit;
            s3_dead  <= s2_dead;
            for (int i = 0; i < PIX_PER_CLK; i++) begin
                epd_sd[2*i +: 2] <= (s3_valid && !s3_dead) ? drive[i] : DRIVE_NONE;
            end
        end
    end

    // Killed words go back to the framebuffer untouched
    always_ff @(posedge clk) begin
        for (int i = 0; i < PIX_PER_CLK; i++) begin
            bo_pixel[16*i +: 16] <= s3_dead ? s3_state[i] : next_state[i];
        end
    end

endmodule

`default_nettype wire

// ==== epd_caster_asserts.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// EPD controller assertions
// Stream handshake and pipeline timing checks, bound into the top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module epd_caster_asserts (
    input logic       clk,
    input logic       rst,
    input logic       fetch,
    input logic       vin_ready,
    input logic       bi_ready,
    input logic       bo_valid,
    input logic       epd_sdce0,
    input logic [7:0] epd_sd
);

    // Three pipeline stages from fetch to output
    a_valid_delay: assert property (@(posedge clk) disable iff (rst)
        bo_valid == $past(fetch, 3))
        else $error("bo_valid is not fetch delayed by three clocks");

    // Both streams lead the panel active region by the pipeline depth
    a_ready_pair: assert property (@(posedge clk) disable iff (rst)
        ($past(vin_ready, 3) == !epd_sdce0) && ($past(bi_ready, 3) == !epd_sdce0))
        else $error("stream ready does not lead the active region by three clocks");

    a_sd_idle: assert property (@(posedge clk) disable iff (rst)
        !bo_valid |-> epd_sd == '0)
        else $error("epd_sd driven while bo_valid is low");

endmodule

bind epd_caster epd_caster_asserts i_asserts (
    .clk       (clk),
    .rst       (rst),
    .fetch     (fetch),
    .vin_ready (vin_ready),
    .bi_ready  (bi_ready),
    .bo_valid  (bo_valid),
    .epd_sdce0 (epd_sdce0),
    .epd_sd    (epd_sd)
);

`default_nettype wire

// ==== epd_caster_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// EPD controller testbench
// Random gray levels and framebuffer states over six frames, checked
// against a pixel model, with one frame killed by a stream underrun
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module epd_caster_tb
    import epd_timing_pkg::*;
    import epd_pixel_pkg::*;
();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_FRAMES   = 6;
    localparam int KILL_FRAME   = 3;
    localparam int KILL_WORD    = 13;
    localparam int HFP = 2;
    localparam int HSYNC = 2;
    localparam int HBP = 3;
    localparam int HACT = 8;
    localparam int VFP = 1;
    localparam int VSYNC = 1;
    localparam int VBP = 1;
    localparam int VACT = 4;
    localparam int LUT_FRAMES = 3;
    localparam int LINES = VFP + VSYNC + VBP + VACT;
    localparam int FRAME_CYCLES = VS_DELAY + 1 + LINES * (HFP + HSYNC + HBP + HACT) + 8;
    localparam int WATCHDOG_CYCLES = LUT_BYTES + RESET_CYCLES + 64
                                   + 2 * FRAME_CYCLES * NUM_FRAMES;

    logic       clk, rst, vin_vsync, vin_valid, vin_ready, bi_valid, bi_ready, bo_valid;
    vin_word_t  vin_pixel;
    fb_word_t   bi_pixel, bo_pixel;
    scan_cfg_t  cfg;
    logic       global_en, sys_ready, lut_we, frame_start;
    lut_waddr_t lut_waddr;
    logic [7:0] lut_wdata, epd_sd;
    logic       epd_gdoe, epd_gdclk, epd_gdsp, epd_sdclk, epd_sdle, epd_sdoe, epd_sdce0;

    int         seed, error_count, frame_idx, frame_words;
    int         fs_count, fetch_count, fetch_lines, run_len, sdle_count;
    int         gdclk_count, sdoe_count;
    logic       model_killed, fs_prev, ready_prev;
    logic [7:0] lut_copy [LUT_BYTES];
    fb_word_t   exp_bo_q [$];
    logic [7:0] exp_sd_q [$];

    epd_caster i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the frames did not complete in the expected time");
        $display("Verification failed");
        $fatal(1, "Watchdog expired");
    end

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            error_count++;
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, actual,
                     expected);
            $display("Verification failed");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    // Random states with small fcnt, gray often equal to src
    task automatic make_words(output vin_word_t vw, output fb_word_t fw);
        logic [31:0] r;
        pix_state_t  st;
        for (int i = 0; i < PIX_PER_CLK; i++) begin
            r = $random(seed);
            st.spare = 2'b00;
            st.fcnt  = r[2] ? fcnt_t'(r[1:0]) : '0;
            st.src   = r[7:4];
            st.tgt   = r[11:8];
            fw[16*i +: 16] = st;
            vw[8*i +: 8]   = {(r[12] ? r[7:4] : r[19:16]), r[23:20]};
        end
    endtask

    task automatic model_word(input vin_word_t vw, input fb_word_t fw, input logic killed,
                              output fb_word_t bo, output logic [7:0] sd);
        pix_state_t st;
        pix_state_t nst;
        gray_t      g;
        wvfm_addr_t addr;
        logic [7:0] lut_byte;
        for (int i = 0; i < PIX_PER_CLK; i++) begin
            st  = fw[16*i +: 16];
            g   = vw[8*i+4 +: 4];
            nst = st;
            sd[2*i +: 2] = DRIVE_NONE;
            if (!killed) begin
                if (st.fcnt != '0) begin
                    addr     = {fcnt_t'(cfg.lut_frames - st.fcnt), st.tgt, st.src};
                    lut_byte = lut_copy[addr[13:2]];
                    sd[2*i +: 2] = lut_byte[2*addr[1:0] +: 2];
                    nst.fcnt = st.fcnt - 6'd1;
                    if (st.fcnt == 6'd1) begin
                        nst.src = st.tgt;
                    end
                end else if (g != st.src) begin
                    nst.tgt  = g;
                    nst.fcnt = cfg.lut_frames;
                end
            end
            bo[16*i +: 16] = nst;
        end
    endtask

    task automatic count_regions();
        if (frame_start && !fs_prev) begin
            fs_count     = 0;
            fetch_count  = 0;
            fetch_lines  = 0;
            sdle_count   = 0;
            gdclk_count  = 0;
            sdoe_count   = 0;
            frame_words  = 0;
            model_killed = 1'b0;
        end
        if (frame_start) fs_count++;
        if (epd_sdle) sdle_count++;
        if (epd_gdclk) gdclk_count++;
        if (epd_sdoe) sdoe_count++;
        if (vin_ready) begin
            fetch_count++;
            run_len++;
            if (!ready_prev) fetch_lines++;
        end else if (ready_prev) begin
            check_value(64'(run_len), 64'(HACT), "fetch run length");
            run_len = 0;
        end
        fs_prev    = frame_start;
        ready_prev = vin_ready;
    endtask

    // One clock: check outputs, then drive the streams for the next edge
    task automatic run_cycle();
        vin_word_t   vw;
        fb_word_t    fw;
        fb_word_t    bo;
        logic [7:0]  sd;
        logic [31:0] r;
        @(negedge clk);
        if (!rst) begin
            if (bo_valid) begin
                check_value(64'(exp_bo_q.size() != 0), 64'd1, "word pending at bo_valid");
                check_value(bo_pixel, exp_bo_q.pop_front(), "bo_pixel");
                check_value(64'(epd_sd), 64'(exp_sd_q.pop_front()), "epd_sd");
            end else begin
                check_value(64'(epd_sd), 64'd0, "epd_sd with bo_valid low");
            end
            count_regions();
        end
        make_words(vw, fw);
        r = $random(seed);
        vin_valid = 1'b1;
        bi_valid  = 1'b1;
        if (frame_idx == KILL_FRAME && frame_words == KILL_WORD) begin
            vin_valid = 1'b0;
            bi_valid  = 1'b0;
        end else if (r[3:0] == 4'd0) begin
            vin_valid = 1'b0;
        end else if (r[3:0] == 4'd1) begin
            bi_valid = 1'b0;
        end
        vin_pixel = vw;
        bi_pixel  = fw;
        if (vin_ready) begin
            if (!vin_valid && !bi_valid) model_killed = 1'b1;
            model_word(vin_valid ? vw : '0, bi_valid ? fw : '0, model_killed, bo, sd);
            exp_bo_q.push_back(bo);
            exp_sd_q.push_back(sd);
            frame_words++;
        end
    endtask

    task automatic check_idle();
        check_value(64'({vin_ready, bi_ready, bo_valid, frame_start, epd_gdoe, epd_sdle,
                         epd_sdclk}), 64'd0, "idle low outputs");
        check_value(64'({epd_gdsp, epd_sdce0}), 64'd3, "idle high outputs");
    endtask

    task automatic run_frame(input int idx);
        frame_idx = idx;
        run_cycle();
        vin_vsync = 1'b1;
        run_cycle();
        vin_vsync = 1'b0;
        do run_cycle(); while (!epd_gdoe);
        do run_cycle(); while (epd_gdoe);
        repeat (4) run_cycle();
        check_value(64'(fs_count), 64'(VS_DELAY + 1), "frame_start clocks");
        check_value(64'(fetch_lines), 64'(VACT), "lines with fetch");
        check_value(64'(fetch_count), 64'(VACT * HACT), "fetch clocks");
        check_value(64'(sdle_count), 64'(HSYNC * LINES), "epd_sdle clocks");
        // Gate clock runs from hsync to the end of every line
        check_value(64'(gdclk_count), 64'(LINES * (HSYNC + HBP + HACT)),
                    "epd_gdclk clocks");
        // Source output enable spans every line after the front porch
        check_value(64'(sdoe_count), 64'((LINES - VFP) * (HFP + HSYNC + HBP + HACT)),
                    "epd_sdoe clocks");
        check_value(64'(exp_bo_q.size()), 64'd0, "words left in pipeline");
    endtask

    initial begin
        logic [31:0] r;
        seed         = 32'hcf3e_8e08;
        error_count  = 0;
        frame_idx    = -1;
        frame_words  = 0;
        fs_count     = 0;
        fetch_count  = 0;
        fetch_lines  = 0;
        run_len      = 0;
        sdle_count   = 0;
        gdclk_count  = 0;
        sdoe_count   = 0;
        model_killed = 1'b0;
        fs_prev      = 1'b0;
        ready_prev   = 1'b0;
        rst          = 1'b1;
        vin_vsync    = 1'b0;
        vin_pixel    = '0;
        vin_valid    = 1'b0;
        bi_pixel     = '0;
        bi_valid     = 1'b0;
        global_en    = 1'b1;
        sys_ready    = 1'b1;
        lut_we       = 1'b0;
        lut_waddr    = '0;
        lut_wdata    = '0;
        cfg = '{vfp: porch_t'(VFP), vsync: porch_t'(VSYNC), vbp: porch_t'(VBP),
                hfp: porch_t'(HFP), hsync: porch_t'(HSYNC), hbp: porch_t'(HBP),
                vact: active_t'(VACT), hact: active_t'(HACT),
                lut_frames: fcnt_t'(LUT_FRAMES)};
        repeat (RESET_CYCLES) run_cycle();
        rst = 1'b0;
        // Waveform table fill, idle outputs checked along the way
        for (int a = 0; a < LUT_BYTES; a++) begin
            r = $random(seed);
            lut_we    = 1'b1;
            lut_waddr = lut_waddr_t'(a);
            lut_wdata = r[7:0];
            lut_copy[lut_waddr] = r[7:0];
            run_cycle();
            check_idle();
        end
        lut_we = 1'b0;
        repeat (20) begin
            run_cycle();
            check_idle();
        end
        for (int f = 0; f < NUM_FRAMES; f++) begin
            run_frame(f);
        end
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== epd_pixel_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// EPD pixel path definitions
// Gray levels, per-pixel framebuffer state, waveform table addressing
// and the widths of the input and framebuffer streams
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package epd_pixel_pkg;

    localparam int PIX_PER_CLK = 4;

    typedef logic [3:0] gray_t;
    typedef logic [5:0] fcnt_t;

    // Framebuffer state word, one per pixel
    typedef struct packed {
        logic [1:0] spare;
        fcnt_t      fcnt;
        gray_t      src;
        gray_t      tgt;
    } pix_state_t;

    // Frame sequence, target, source
    typedef logic [13:0] wvfm_addr_t;
    // Byte address, four 2-bit entries per byte
    typedef logic [11:0] lut_waddr_t;

    localparam int LUT_BYTES = 2 ** $bits(lut_waddr_t);

    typedef logic [1:0] drive_t;
    localparam drive_t DRIVE_NONE = 2'b00;

    typedef logic [31:0] vin_word_t;
    typedef logic [63:0] fb_word_t;

endpackage

`default_nettype wire

// ==== epd_scan_timing.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// EPD scan timing generator
// Waits for vsync, then walks porch, sync and active regions line by
// line. Produces the stream fetch window and gate/source driver controls
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module epd_scan_timing
    import epd_timing_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  scan_cfg_t cfg,
    input  logic      global_en,
    input  logic      sys_ready,
    input  logic      vin_vsync,
    output logic      fetch,
    output logic      frame_begin,
    output logic      killable,
    output logic      epd_gdoe,
    output logic      epd_gdclk,
    output logic      epd_gdsp,
    output logic      epd_sdclk,
    output logic      epd_sdle,
    output logic      epd_sdoe,
    output logic      epd_sdce0
);

    scan_state_t state;
    scan_cnt_t   h_cnt;
    scan_cnt_t   v_cnt;

    scan_cnt_t v_sync_start, v_bp_start, v_act_start, v_total;
    scan_cnt_t h_sync_start, h_bp_start, h_act_start, h_total;
    scan_cnt_t fetch_start, fetch_end;

    logic running;
    logic in_vsync, in_vbp, in_vact;
    logic in_hfp, in_hsync, in_hbp, in_hact;

    // Region boundaries, running sums of the configured lengths
    always_comb begin
        v_sync_start = scan_cnt_t'(cfg.vfp);
        v_bp_start   = v_sync_start + scan_cnt_t'(cfg.vsync);
        v_act_start  = v_bp_start + scan_cnt_t'(cfg.vbp);
        v_total      = v_act_start + scan_cnt_t'(cfg.vact);
        h_sync_start = scan_cnt_t'(cfg.hfp);
        h_bp_start   = h_sync_start + scan_cnt_t'(cfg.hsync);
        h_act_start  = h_bp_start + scan_cnt_t'(cfg.hbp);
        h_total      = h_act_start + scan_cnt_t'(cfg.hact);
        // Fetch runs ahead of the active region by the pipeline depth
        fetch_start  = h_act_start - scan_cnt_t'(PIPELINE_DELAY);
        fetch_end    = h_total - scan_cnt_t'(PIPELINE_DELAY);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= SCAN_IDLE;
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            case (state)
                SCAN_IDLE: begin
                    h_cnt <= '0;
                    v_cnt <= '0;
                    if (sys_ready && global_en && vin_vsync) begin
                        state <= SCAN_WAITING;
                    end
                end
                SCAN_WAITING: begin
                    // h_cnt doubles as the vsync delay counter
                    if (h_cnt == scan_cnt_t'(VS_DELAY)) begin
                        state <= SCAN_RUNNING;
                        h_cnt <= '0;
                    end else begin
                        h_cnt <= h_cnt + 1'b1;
                    end
                end
                SCAN_RUNNING: begin
                    if (h_cnt == h_total - 1'b1) begin
                        h_cnt <= '0;
                        if (v_cnt == v_total - 1'b1) begin
                            state <= SCAN_IDLE;
                        end else begin
                            v_cnt <= v_cnt + 1'b1;
                        end
                    end else begin
                        h_cnt <= h_cnt + 1'b1;
                    end
                end
                default: state <= SCAN_IDLE;
            endcase
        end
    end

    assign running  = (state == SCAN_RUNNING);

    assign in_vsync = running && (v_cnt >= v_sync_start) && (v_cnt < v_bp_start);
    assign in_vbp   = running && (v_cnt >= v_bp_start) && (v_cnt < v_act_start);
    assign in_vact  = running && (v_cnt >= v_act_start);
    assign in_hfp   = running && (h_cnt < h_sync_start);
    assign in_hsync = running && (h_cnt >= h_sync_start) && (h_cnt < h_bp_start);
    assign in_hbp   = running && (h_cnt >= h_bp_start) && (h_cnt < h_act_start);
    assign in_hact  = running && (h_cnt >= h_act_start);

    assign fetch       = in_vact && (h_cnt >= fetch_start) && (h_cnt < fetch_end);
    assign frame_begin = (state == SCAN_WAITING);
    assign killable    = running;

    // Gate driver
    assign epd_gdoe = in_vsync || in_vbp || in_vact;
    assign epd_gdsp = !in_vsync;

    // Source driver
    assign epd_sdoe  = epd_gdoe;
    assign epd_sdle  = in_hsync;
    assign epd_sdce0 = !(in_vact && in_hact);

    // Clock enables, turned into clocks by the board output register
    always_ff @(posedge clk) begin
        if (rst) begin
            epd_gdclk <= 1'b0;
            epd_sdclk <= 1'b0;
        end else begin
            epd_gdclk <= in_hsync || in_hbp || in_hact;
            epd_sdclk <= in_hfp || in_hsync || in_hact;
        end
    end

endmodule

`default_nettype wire

// ==== epd_timing_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// EPD scan timing definitions
// Frame geometry, scan FSM states and the fixed delays that the scan
// generator and the pixel pipeline agree on
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package epd_timing_pkg;

    // Clocks spent in WAITING after vsync, counted from zero
    localparam int VS_DELAY = 8;
    // Fetch to panel output, in clocks
    localparam int PIPELINE_DELAY = 3;

    typedef logic [7:0]  porch_t;
    typedef logic [11:0] active_t;
    typedef logic [10:0] scan_cnt_t;

    // Held static while a frame runs
    typedef struct packed {
        porch_t     vfp;
        porch_t     vsync;
        porch_t     vbp;
        porch_t     hfp;
        porch_t     hsync;
        porch_t     hbp;
        active_t    vact;
        active_t    hact;
        logic [5:0] lut_frames;
    } scan_cfg_t;

    typedef enum logic [1:0] {
        SCAN_IDLE,
        SCAN_WAITING,
        SCAN_RUNNING
    } scan_state_t;

endpackage

`default_nettype wire

// ==== pixel_update.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Per-pixel waveform update
// Stage 2 forms the table address, stage 3 picks the drive value and
// advances the framebuffer state word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module pixel_update
    import epd_pixel_pkg::*;
(
    input  logic       clk,
    input  fcnt_t      lut_frames,
    input  gray_t      vin_gray,
    input  pix_state_t state_in,
    input  drive_t     drive_rd,
    output wvfm_addr_t wvfm_addr,
    output pix_state_t state_out,
    output drive_t     drive
);

    fcnt_t      fseq;
    pix_state_t s3_state;
    gray_t      s3_gray;

    // Sequence counts up from zero as fcnt counts down
    assign fseq      = lut_frames - state_in.fcnt;
    assign wvfm_addr = {fseq, state_in.tgt, state_in.src};

    always_ff @(posedge clk) begin
        s3_state <= state_in;
        s3_gray  <= vin_gray;
    end

    always_comb begin
        state_out = s3_state;
        drive     = DRIVE_NONE;
        if (s3_state.fcnt != '0) begin
            // Transition in progress
            drive          = drive_rd;
            state_out.fcnt = s3_state.fcnt - 1'b1;
            if (s3_state.fcnt == fcnt_t'(1)) begin
                state_out.src = s3_state.tgt;
            end
        end else if (s3_gray != s3_state.src) begin
            // New target, drive starts next frame
            state_out.tgt  = s3_gray;
            state_out.fcnt = lut_frames;
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Builds the EPD controller testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f epd_caster.f --top-module epd_caster_tb \
    -Mdir obj_dir -o epd_caster_sim
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/epd_caster_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Verification failed" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $status -ne 0 ] || ! grep -q "Verification passed" "$LOG"; then
    echo "Simulation did not complete"
    exit 1
fi
exit 0

// ==== wvfm_lut.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Waveform table
// 4096 bytes of 2-bit drive entries, byte-wide write port and one
// registered 2-bit read port per pixel
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module wvfm_lut
    import epd_pixel_pkg::*;
(
    input  logic                     clk,
    input  logic                     we,
    input  lut_waddr_t               waddr,
    input  logic [7:0]               wdata,
    input  wvfm_addr_t               raddr [PIX_PER_CLK],
    output logic [2*PIX_PER_CLK-1:0] rdata
);

    logic [7:0] lut_mem [LUT_BYTES];

    always_ff @(posedge clk) begin
        if (we) begin
            lut_mem[waddr] <= wdata;
        end
    end

    for (genvar i = 0; i < PIX_PER_CLK; i++) begin : g_rd_port
        lut_waddr_t rd_byte;
        logic [1:0] rd_sel;
        logic [7:0] rd_word;

        // Upper bits pick the byte, low two bits the entry within it
        assign rd_byte = raddr[i][13:2];
        assign rd_sel  = raddr[i][1:0];
        assign rd_word = lut_mem[rd_byte];

        always_ff @(posedge clk) begin
            rdata[2*i +: 2] <= rd_word[2*rd_sel +: 2];
        end
    end

endmodule

`default_nettype wire
